/* verilog/vdp_pkg.sv */
// --------------------
// shared types for the video display processor
// vram is 64K x 16 bits, palette is 256 x 12 bits
// raster counters are CNT_W bits, so a line or frame total
// must stay below 4096
// --------------------
package vdp_pkg;

    localparam int VRAM_AW = 16;        // word address, 64K words
    localparam int COLOR_W = 12;        // 4 bits each of r, g, b
    localparam int CNT_W   = 12;        // raster column / row counters

    // host register numbers
    typedef enum logic [3:0] {
        REG_ADDR     = 4'd0,            // vram word address
        REG_DATA     = 4'd1,            // vram data, read gives prefetched word
        REG_MASK     = 4'd2,            // nibble write mask in bits 3:0
        REG_PAL_ADDR = 4'd3,            // palette index
        REG_PAL_DATA = 4'd4,            // palette color, index auto-increments
        REG_CTRL     = 4'd5,            // bit 0 video enable
        REG_STATUS   = 4'd6             // bit 0 busy, bit 1 vblank
    } vdp_reg_e;

    // bus controller FSM
    typedef enum logic [2:0] {
        IDLE,
        WAIT_SLOT,                      // request held until granted
        WRITE,                          // write taken, bump address
        READ,                           // bump address before prefetch
        CAPTURE                         // latch prefetched word
    } bus_state_e;

    typedef struct packed {
        logic               sel;        // level, held until granted
        logic               wr;
        logic [3:0]         mask;       // one bit per nibble
        logic [VRAM_AW-1:0] addr;
        logic [15:0]        data;
    } vram_req_t;

    typedef struct packed {
        logic               wr;         // single cycle pulse
        logic [7:0]         index;
        logic [COLOR_W-1:0] color;
    } pal_wr_t;

    typedef struct packed {
        logic hsync;                    // active low
        logic vsync;                    // active low
        logic de;
    } sync_t;

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

endpackage

/* verilog/vdp_vram.sv */
// --------------------
// 64K x 16 synchronous video ram, single port
// write is per nibble under mask, read gives the old word
// read data one cycle after sel
// --------------------
`timescale 1ns/10ps

module vdp_vram
    import vdp_pkg::*;
(
    input  logic        clk,
    input  vram_req_t   req_i,
    output logic [15:0] rdata_o
);

    logic [15:0] mem [2**VRAM_AW];

    always_ff @(posedge clk) begin
        if (req_i.sel) begin
            if (req_i.wr) begin
                for (int n = 0; n < 4; n++) begin
                    if (req_i.mask[n]) begin
                        mem[req_i.addr][n*4 +: 4] <= req_i.data[n*4 +: 4];
                    end
                end
            end
            rdata_o <= mem[req_i.addr];     // read before write
        end
    end

endmodule

/* verilog/vdp_palette.sv */
// --------------------
// 256 entry color ram
// host write port, registered video read
// --------------------
`timescale 1ns/10ps

module vdp_palette
    import vdp_pkg::*;
(
    input  logic               clk,
    input  pal_wr_t            wr_i,
    input  logic [7:0]         rd_index_i,
    output logic [COLOR_W-1:0] rd_color_o
);

    logic [COLOR_W-1:0] mem [256];

    always_ff @(posedge clk) begin
        if (wr_i.wr) begin
            mem[wr_i.index] <= wr_i.color;
        end
        rd_color_o <= mem[rd_index_i];      // color one cycle after index
    end

endmodule

/* verilog/vdp_raster_timer.sv */
// --------------------
// raster counters, visible region first on both axes
// then front porch, sync, back porch
// outputs are decoded straight from the counters
// --------------------
`timescale 1ns/10ps

module vdp_raster_timer
    import vdp_pkg::*;
#(
    parameter int H_VIS  = 16,
    parameter int H_FP   = 2,
    parameter int H_SYNC = 3,
    parameter int H_BP   = 3,
    parameter int V_VIS  = 6,
    parameter int V_FP   = 1,
    parameter int V_SYNC = 1,
    parameter int V_BP   = 1
) (
    input  logic             clk,
    input  logic             rst_i,
    output logic [CNT_W-1:0] col_o,
    output logic [CNT_W-1:0] row_o,
    output sync_t            sync_o,
    output logic             frame_pulse_o,     // first line after the visible ones
    output logic             in_vblank_o
);

    localparam int H_TOTAL   = H_VIS + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL   = V_VIS + V_FP + V_SYNC + V_BP;
    localparam int H_SYNC_ON = H_VIS + H_FP;
    localparam int V_SYNC_ON = V_VIS + V_FP;

    logic line_end;
    logic frame_end;

    assign line_end  = (col_o == CNT_W'(H_TOTAL - 1));
    assign frame_end = (row_o == CNT_W'(V_TOTAL - 1));

    always_ff @(posedge clk) begin
        if (rst_i) begin
            col_o <= '0;
            row_o <= '0;
        end else if (line_end) begin
            col_o <= '0;
            row_o <= frame_end ? '0 : row_o + 1'b1;
        end else begin
            col_o <= col_o + 1'b1;
        end
    end

    // region decode
    always_comb begin
        sync_o.hsync = !((col_o >= CNT_W'(H_SYNC_ON)) &&
                         (col_o <  CNT_W'(H_SYNC_ON + H_SYNC)));
        sync_o.vsync = !((row_o >= CNT_W'(V_SYNC_ON)) &&
                         (row_o <  CNT_W'(V_SYNC_ON + V_SYNC)));
        sync_o.de    = (col_o < CNT_W'(H_VIS)) && (row_o < CNT_W'(V_VIS));
    end

    assign in_vblank_o   = (row_o >= CNT_W'(V_VIS));
    assign frame_pulse_o = (row_o == CNT_W'(V_VIS)) && (col_o == '0);

endmodule

/* verilog/vdp_pixel_fetch.sv */
// --------------------
// vram arbiter plus pixel pipeline
// video owns the ram on every even visible column while enabled
// one word = two pixels, even pixel in the high byte
// H_VIS must be even
// --------------------
`timescale 1ns/10ps

module vdp_pixel_fetch
    import vdp_pkg::*;
#(
    parameter int H_VIS = 16
) (
    input  logic             clk,
    input  logic             rst_i,
    input  logic [CNT_W-1:0] col_i,
    input  logic [CNT_W-1:0] row_i,
    input  sync_t            sync_i,
    input  logic             video_ena_i,
    input  vram_req_t        host_req_i,
    input  logic [15:0]      vram_rdata_i,
    output vram_req_t        vram_req_o,
    output logic             host_grant_o,
    output logic [7:0]       pal_index_o,
    output sync_t            sync_o,
    output logic             blank_o
);

    localparam sync_t SYNC_IDLE = '{hsync: 1'b1, vsync: 1'b1, de: 1'b0};

    logic               video_take;         // video owns the ram this cycle
    logic [VRAM_AW-1:0] line_base;          // word address of the current line
    logic [VRAM_AW-1:0] line_start;
    logic [VRAM_AW-1:0] vid_addr;
    logic               odd_q;              // pixel phase, aligned with rdata
    logic [7:0]         low_hold;           // odd pixel of the last word
    sync_t              sync_d1;
    logic [1:0]         blank_q;

    assign video_take = video_ena_i && sync_i.de && !col_i[0];

    // running address, no multiply
    assign line_start = (row_i == '0) ? '0 : line_base;
    assign vid_addr   = line_start + VRAM_AW'(col_i >> 1);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            line_base <= '0;
        end else if (sync_i.de && col_i == CNT_W'(H_VIS - 1)) begin
            line_base <= line_start + VRAM_AW'(H_VIS / 2);  // step one line
        end
    end

    always_comb begin
        if (video_take) begin
            vram_req_o.sel  = 1'b1;
            vram_req_o.wr   = 1'b0;
            vram_req_o.mask = 4'h0;
            vram_req_o.addr = vid_addr;
            vram_req_o.data = 16'h0000;
        end else begin
            vram_req_o = host_req_i;
        end
    end

    assign host_grant_o = host_req_i.sel && !video_take;    // pulse, host drops sel after

    // odd pixel uses the low byte saved in the even cycle
    always_ff @(posedge clk) begin
        if (!odd_q) begin
            low_hold <= vram_rdata_i[7:0];
        end
    end

    assign pal_index_o = odd_q ? low_hold : vram_rdata_i[15:8];

    // sync and blank follow the 2 cycle index + palette path
    always_ff @(posedge clk) begin
        if (rst_i) begin
            odd_q   <= 1'b0;
            sync_d1 <= SYNC_IDLE;
            sync_o  <= SYNC_IDLE;
            blank_q <= 2'b11;
        end else begin
            odd_q   <= col_i[0];
            sync_d1 <= sync_i;
            sync_o  <= sync_d1;
            blank_q <= {blank_q[0], !(sync_i.de && video_ena_i)};
        end
    end

    assign blank_o = blank_q[1];

endmodule

/* verilog/vdp_bus_ctrl.sv */
// --------------------
// host register interface, plain strobes with no acknowledge
// host must poll busy before the next REG_ADDR / REG_DATA access
// vram commands arriving while busy are dropped
// --------------------
`timescale 1ns/10ps

module vdp_bus_ctrl
    import vdp_pkg::*;
(
    input  logic        clk,
    input  logic        rst_i,
    input  logic        bus_cs_n_i,
    input  logic        bus_rd_nwr_i,       // 0 = write
    input  vdp_reg_e    bus_reg_num_i,
    input  logic        bus_bytesel_i,      // 0 = even (high) byte
    input  logic [7:0]  bus_data_i,
    input  logic        in_vblank_i,
    input  logic        vram_grant_i,
    input  logic [15:0] vram_rdata_i,
    output logic [7:0]  bus_data_o,
    output vram_req_t   vram_req_o,
    output pal_wr_t     pal_wr_o,
    output logic        video_ena_o
);

    bus_state_e         state;
    logic [7:0]         even_byte;          // high byte waiting for its partner
    logic [VRAM_AW-1:0] addr;
    logic [3:0]         mask;
    logic [7:0]         pal_index;
    logic [15:0]        wr_data;
    logic [15:0]        rd_data;            // prefetched word
    logic               op_wr;              // pending access is a write

    logic               wr_strobe;
    logic               rd_strobe;
    logic               commit;
    logic               busy;
    logic [15:0]        commit_word;
    logic [15:0]        reg_word;

    assign wr_strobe   = !bus_cs_n_i && !bus_rd_nwr_i;
    assign rd_strobe   = !bus_cs_n_i && bus_rd_nwr_i;
    assign commit      = wr_strobe && bus_bytesel_i;     // odd byte completes the word
    assign commit_word = {even_byte, bus_data_i};
    assign busy        = (state == WAIT_SLOT) || (state == READ);

    always_comb begin
        vram_req_o.sel  = (state == WAIT_SLOT);
        vram_req_o.wr   = op_wr;
        vram_req_o.mask = mask;
        vram_req_o.addr = addr;
        vram_req_o.data = wr_data;
    end

    // register readback mux
    always_comb begin
        case (bus_reg_num_i)
            REG_ADDR:     reg_word = 16'(addr);
            REG_DATA:     reg_word = rd_data;
            REG_MASK:     reg_word = {12'h000, mask};
            REG_PAL_ADDR: reg_word = {8'h00, pal_index};
            REG_CTRL:     reg_word = {15'h0000, video_ena_o};
            REG_STATUS:   reg_word = {14'h0000, in_vblank_i, busy};
            default:      reg_word = 16'h0000;  // palette data is write only
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state       <= IDLE;
            addr        <= '0;
            mask        <= 4'h0;                // nothing written until mask set
            pal_index   <= 8'h00;
            video_ena_o <= 1'b0;
            op_wr       <= 1'b0;
            pal_wr_o    <= '0;
            bus_data_o  <= 8'h00;
        end else begin
            pal_wr_o.wr <= 1'b0;

            if (wr_strobe && !bus_bytesel_i) begin
                even_byte <= bus_data_i;
            end

            if (rd_strobe) begin
                bus_data_o <= bus_bytesel_i ? reg_word[7:0] : reg_word[15:8];
            end

            // registers outside the vram path, taken in any state
            if (commit) begin
                case (bus_reg_num_i)
                    REG_MASK:     mask <= commit_word[3:0];
                    REG_PAL_ADDR: pal_index <= commit_word[7:0];
                    REG_PAL_DATA: begin
                        pal_wr_o.wr    <= 1'b1;
                        pal_wr_o.index <= pal_index;
                        pal_wr_o.color <= commit_word[COLOR_W-1:0];
                        pal_index      <= pal_index + 8'd1;
                    end
                    REG_CTRL:     video_ena_o <= commit_word[0];
                    default: ;
                endcase
            end

            case (state)
                IDLE: begin
                    if (commit && bus_reg_num_i == REG_DATA) begin
                        wr_data <= commit_word;
                        op_wr   <= 1'b1;
                        state   <= WAIT_SLOT;
                    end else if (commit && bus_reg_num_i == REG_ADDR) begin
                        addr  <= commit_word[VRAM_AW-1:0];
                        op_wr <= 1'b0;          // prefetch from new address
                        state <= WAIT_SLOT;
                    end else if (rd_strobe && bus_bytesel_i && bus_reg_num_i == REG_DATA) begin
                        op_wr <= 1'b0;
                        state <= READ;          // word consumed, fetch the next
                    end
                end
                READ: begin
                    addr  <= addr + 1'b1;
                    state <= WAIT_SLOT;
                end
                WAIT_SLOT: begin
                    if (vram_grant_i) begin
                        state <= op_wr ? WRITE : CAPTURE;
                    end
                end
                WRITE: begin
                    addr  <= addr + 1'b1;
                    state <= IDLE;
                end
                CAPTURE: begin
                    rd_data <= vram_rdata_i;    // valid one cycle after grant
                    state   <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* verilog/vdp_top.sv */
// --------------------
// video display processor top level
// pins trail the raster counters by 3 cycles
// rgb is zero outside de or with video disabled
// --------------------
`timescale 1ns/10ps

module vdp_top
    import vdp_pkg::*;
#(
    parameter int H_VIS  = 16,
    parameter int H_FP   = 2,
    parameter int H_SYNC = 3,
    parameter int H_BP   = 3,
    parameter int V_VIS  = 6,
    parameter int V_FP   = 1,
    parameter int V_SYNC = 1,
    parameter int V_BP   = 1
) (
    input  logic       clk,
    input  logic       rst_i,
    input  logic       bus_cs_n_i,
    input  logic       bus_rd_nwr_i,
    input  logic [3:0] bus_reg_num_i,
    input  logic       bus_bytesel_i,
    input  logic [7:0] bus_data_i,
    output logic [7:0] bus_data_o,
    output logic       bus_intr_o,          // once per frame
    output logic [3:0] red_o,
    output logic [3:0] green_o,
    output logic [3:0] blue_o,
    output logic       hsync_o,
    output logic       vsync_o,
    output logic       dv_de_o
);

    logic [CNT_W-1:0]   col;
    logic [CNT_W-1:0]   row;
    sync_t              raster_sync;
    sync_t              fetch_sync;         // delayed to match the color
    logic               frame_pulse;
    logic               in_vblank;
    logic               video_ena;
    vram_req_t          host_req;
    vram_req_t          vram_req;
    logic               host_grant;
    logic [15:0]        vram_rdata;
    pal_wr_t            pal_wr;
    logic [7:0]         pal_index;
    logic [COLOR_W-1:0] color;
    logic               blank;
    logic [2:0]         intr_pipe;
    rgb_t               rgb_q;

    vdp_bus_ctrl i_bus_ctrl (
        .clk           (clk),
        .rst_i         (rst_i),
        .bus_cs_n_i    (bus_cs_n_i),
        .bus_rd_nwr_i  (bus_rd_nwr_i),
        .bus_reg_num_i (vdp_reg_e'(bus_reg_num_i)),
        .bus_bytesel_i (bus_bytesel_i),
        .bus_data_i    (bus_data_i),
        .in_vblank_i   (in_vblank),
        .vram_grant_i  (host_grant),
        .vram_rdata_i  (vram_rdata),
        .bus_data_o    (bus_data_o),
        .vram_req_o    (host_req),
        .pal_wr_o      (pal_wr),
        .video_ena_o   (video_ena)
    );

    vdp_raster_timer #(
        .H_VIS  (H_VIS),
        .H_FP   (H_FP),
        .H_SYNC (H_SYNC),
        .H_BP   (H_BP),
        .V_VIS  (V_VIS),
        .V_FP   (V_FP),
        .V_SYNC (V_SYNC),
        .V_BP   (V_BP)
    ) i_raster_timer (
        .clk           (clk),
        .rst_i         (rst_i),
        .col_o         (col),
        .row_o         (row),
        .sync_o        (raster_sync),
        .frame_pulse_o (frame_pulse),
        .in_vblank_o   (in_vblank)
    );

    vdp_pixel_fetch #(
        .H_VIS (H_VIS)
    ) i_pixel_fetch (
        .clk          (clk),
        .rst_i        (rst_i),
        .col_i        (col),
        .row_i        (row),
        .sync_i       (raster_sync),
        .video_ena_i  (video_ena),
        .host_req_i   (host_req),
        .vram_rdata_i (vram_rdata),
        .vram_req_o   (vram_req),
        .host_grant_o (host_grant),
        .pal_index_o  (pal_index),
        .sync_o       (fetch_sync),
        .blank_o      (blank)
    );

    vdp_vram i_vram (
        .clk     (clk),
        .req_i   (vram_req),
        .rdata_o (vram_rdata)
    );

    vdp_palette i_palette (
        .clk        (clk),
        .wr_i       (pal_wr),
        .rd_index_i (pal_index),
        .rd_color_o (color)
    );

    // pin registers, last stage of the 3 cycle path
    always_ff @(posedge clk) begin
        if (rst_i) begin
            hsync_o   <= 1'b1;                  // inactive
            vsync_o   <= 1'b1;
            dv_de_o   <= 1'b0;
            rgb_q     <= '0;
            intr_pipe <= 3'b000;
        end else begin
            hsync_o   <= fetch_sync.hsync;
            vsync_o   <= fetch_sync.vsync;
            dv_de_o   <= fetch_sync.de;
            rgb_q     <= blank ? '0 : rgb_t'(color);
            intr_pipe <= {intr_pipe[1:0], frame_pulse};   // match the pixel delay
        end
    end

    assign bus_intr_o = intr_pipe[2];
    assign red_o      = rgb_q.red;
    assign green_o    = rgb_q.green;
    assign blue_o     = rgb_q.blue;

endmodule

/* verification/tb_vdp.sv */
// --------------------
// testbench for vdp_top at the default small geometry
// vram model covers the whole 64K, only written words are compared
// pixel and raster checks start at the first vsync release after reset
// --------------------
`timescale 1ns/10ps

module tb_vdp
    import vdp_pkg::*;
();

    localparam int H_VIS   = 16;
    localparam int H_FP    = 2;
    localparam int H_SYNC  = 3;
    localparam int H_BP    = 3;
    localparam int V_VIS   = 6;
    localparam int V_FP    = 1;
    localparam int V_SYNC  = 1;
    localparam int V_BP    = 1;
    localparam int H_TOTAL = H_VIS + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL = V_VIS + V_FP + V_SYNC + V_BP;
    localparam int TIMEOUT = 20 * H_TOTAL * V_TOTAL + 4000;    // 20 frames plus register work
    localparam int N_WORDS = 40;
    localparam int N_CONT  = 16;                // words moved while video runs
    localparam int PIX_NONE  = 0;               // de cycles not compared
    localparam int PIX_COLOR = 1;
    localparam int PIX_BLACK = 2;

    logic       clk;
    logic       rst;
    logic       cs_n;
    logic       rd_nwr;
    logic [3:0] reg_num;
    logic       bytesel;
    logic [7:0] data_in;
    logic [7:0] bus_data;
    logic       bus_intr;
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
    logic       hsync;
    logic       vsync;
    logic       de;

    integer      seed;
    int          errors;
    int          cycles;
    int          pix_mode;
    logic [15:0] vram_m [0:65535];
    logic [11:0] pal_m [0:255];
    logic [15:0] start_addr;
    logic [15:0] base;
    logic [15:0] word;
    logic [3:0]  m;

    // raster monitor state, pin level
    logic        armed;
    logic        vb_pin;                    // between interrupt and first de
    logic        prev_hs;
    logic        prev_vs;
    logic        prev_de;
    int          frames;
    int          hs_len;
    int          vs_len;
    int          de_len;
    int          de_lines;                  // also the pixel row
    int          hs_pulses;
    int          intr_cnt;
    int          px_col;
    logic [15:0] pix_word;
    logic [7:0]  pix_idx;

    vdp_top #(
        .H_VIS  (H_VIS),
        .H_FP   (H_FP),
        .H_SYNC (H_SYNC),
        .H_BP   (H_BP),
        .V_VIS  (V_VIS),
        .V_FP   (V_FP),
        .V_SYNC (V_SYNC),
        .V_BP   (V_BP)
    ) i_vdp_top (
        .clk           (clk),
        .rst_i         (rst),
        .bus_cs_n_i    (cs_n),
        .bus_rd_nwr_i  (rd_nwr),
        .bus_reg_num_i (reg_num),
        .bus_bytesel_i (bytesel),
        .bus_data_i    (data_in),
        .bus_data_o    (bus_data),
        .bus_intr_o    (bus_intr),
        .red_o         (red),
        .green_o       (green),
        .blue_o        (blue),
        .hsync_o       (hsync),
        .vsync_o       (vsync),
        .dv_de_o       (de)
    );

    always #5 clk = ~clk;

    task automatic check_val(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, act, exp);
        end
    endtask

    // even byte first, odd byte commits
    task automatic write_reg(input vdp_reg_e r, input logic [15:0] w);
        @(posedge clk);
        cs_n    <= 1'b0;
        rd_nwr  <= 1'b0;
        reg_num <= r;
        bytesel <= 1'b0;
        data_in <= w[15:8];
        @(posedge clk);
        bytesel <= 1'b1;
        data_in <= w[7:0];
        @(posedge clk);
        cs_n    <= 1'b1;
    endtask

    task automatic read_reg(input vdp_reg_e r, output logic [15:0] w);
        @(posedge clk);
        cs_n    <= 1'b0;
        rd_nwr  <= 1'b1;
        reg_num <= r;
        bytesel <= 1'b0;
        @(posedge clk);
        bytesel <= 1'b1;
        @(negedge clk);
        w[15:8] = bus_data;                 // registered one cycle after strobe
        @(posedge clk);
        cs_n    <= 1'b1;
        @(negedge clk);
        w[7:0]  = bus_data;
    endtask

    // status sample lines up with the pins 2 cycles later
    task automatic read_status(output logic [15:0] st);
        read_reg(REG_STATUS, st);
        @(negedge clk);
        @(negedge clk);
        @(posedge clk);
        check_val("bus_data_o status vblank", st[1], vb_pin);
    endtask

    task automatic wait_not_busy();
        logic [15:0] st;
        read_status(st);
        while (st[0]) begin
            read_status(st);
        end
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = frames + n;
        while (frames < target) begin
            @(posedge clk);
        end
    endtask

    function automatic logic [15:0] apply_nibble_mask(input logic [15:0] old_w,
                                                      input logic [15:0] new_w,
                                                      input logic [3:0]  msk);
        logic [15:0] take_new;
        // mask bit n selects nibble n
        take_new = {{4{msk[3]}}, {4{msk[2]}}, {4{msk[1]}}, {4{msk[0]}}};
        return (new_w & take_new) | (old_w & ~take_new);
    endfunction

    // set address, then read words back through the prefetch
    task automatic readback(input logic [15:0] a, input int n);
        logic [15:0] w;
        write_reg(REG_ADDR, a);
        wait_not_busy();
        for (int i = 0; i < n; i++) begin
            read_reg(REG_DATA, w);
            check_val("bus_data_o REG_DATA", w, vram_m[a + i]);
            wait_not_busy();
        end
    endtask

    task automatic write_words(input logic [15:0] a, input int n);
        logic [15:0] w;
        write_reg(REG_ADDR, a);
        wait_not_busy();
        for (int i = 0; i < n; i++) begin
            w = 16'($random(seed));
            vram_m[a + i] = w;
            write_reg(REG_DATA, w);
            wait_not_busy();
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout: run still going after %0d cycles", TIMEOUT);
            $display("Result: FAILED");
            $finish;
        end
    end

    // raster, interrupt and pixel monitor
    always @(negedge clk) begin
        if (rst) begin
            armed    = 1'b0;
            vb_pin   = 1'b0;
            prev_hs  = 1'b1;
            prev_vs  = 1'b1;
            prev_de  = 1'b0;
            frames   = 0;
            hs_len   = 0;
            vs_len   = 0;
            de_len   = 0;
            de_lines = 0;
            px_col   = 0;
        end else begin
            if (bus_intr) begin
                vb_pin = 1'b1;
            end else if (de) begin
                vb_pin = 1'b0;
            end
            if (armed) begin
                if (!hsync) hs_len++;
                if (!vsync) vs_len++;
                if (hsync && !prev_hs) begin        // end of hsync pulse
                    check_val("hsync_o low cycles", hs_len, H_SYNC);
                    hs_pulses++;
                    hs_len = 0;
                end
                if (bus_intr) begin
                    intr_cnt++;
                    check_val("de lines before bus_intr_o", de_lines, V_VIS);
                end
                if (de) begin
                    if (pix_mode == PIX_COLOR) begin
                        pix_word = vram_m[de_lines * (H_VIS / 2) + px_col / 2];
                        pix_idx  = (px_col % 2) ? pix_word[7:0] : pix_word[15:8];
                        check_val("{red_o,green_o,blue_o}", {red, green, blue}, pal_m[pix_idx]);
                    end else if (pix_mode == PIX_BLACK) begin
                        check_val("{red_o,green_o,blue_o} disabled", {red, green, blue}, 0);
                    end
                    de_len++;
                    px_col++;
                end else begin
                    check_val("{red_o,green_o,blue_o} outside de", {red, green, blue}, 0);
                    if (prev_de) begin
                        check_val("dv_de_o cycles per line", de_len, H_VIS);
                        de_lines++;
                        de_len = 0;
                        px_col = 0;
                    end
                end
            end
            if (vsync && !prev_vs) begin            // frame boundary
                if (armed) begin
                    check_val("vsync_o low cycles", vs_len, V_SYNC * H_TOTAL);
                    check_val("dv_de_o lines per frame", de_lines, V_VIS);
                    check_val("bus_intr_o pulses per frame", intr_cnt, 1);
                    check_val("hsync_o pulses per frame", hs_pulses, V_TOTAL);
                    frames++;
                end
                armed     = 1'b1;
                hs_len    = 0;
                vs_len    = 0;
                de_lines  = 0;
                hs_pulses = 0;
                intr_cnt  = 0;
            end
            prev_hs = hsync;
            prev_vs = vsync;
            prev_de = de;
        end
    end

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        cs_n     = 1'b1;
        rd_nwr   = 1'b0;
        reg_num  = 4'h0;
        bytesel  = 1'b0;
        data_in  = 8'h00;
        seed     = 32'hcd79;
        errors   = 0;
        cycles   = 0;
        pix_mode = PIX_BLACK;                       // video off after reset
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // write and readback, clear of the frame area
        start_addr = 16'h0100 + 16'($random(seed) & 32'h7fff);
        write_reg(REG_MASK, 16'h000f);
        write_words(start_addr, N_WORDS);
        readback(start_addr, N_WORDS);

        // rewrite under random nibble masks
        write_reg(REG_ADDR, start_addr);
        wait_not_busy();
        for (int i = 0; i < N_WORDS; i++) begin
            m    = 4'($random(seed));
            word = 16'($random(seed));
            write_reg(REG_MASK, {12'h000, m});
            write_reg(REG_DATA, word);
            wait_not_busy();
            vram_m[start_addr + i] = apply_nibble_mask(vram_m[start_addr + i], word, m);
        end
        readback(start_addr, N_WORDS);

        wait_frames(2);                             // raster only, rgb black

        // frame words at 0 and a random palette
        write_reg(REG_MASK, 16'h000f);
        write_words(16'h0000, V_VIS * H_VIS / 2);
        write_reg(REG_PAL_ADDR, 16'h0000);
        for (int i = 0; i < 256; i++) begin
            pal_m[i] = 12'($random(seed));
            write_reg(REG_PAL_DATA, {4'h0, pal_m[i]});
        end
        pix_mode = PIX_NONE;                        // partial frame after enable
        write_reg(REG_CTRL, 16'h0001);
        wait_frames(1);
        pix_mode = PIX_COLOR;
        wait_frames(2);

        // host traffic against video fetch, pixels still compared
        base = start_addr + 16'(N_WORDS);
        write_words(base, N_CONT);
        readback(base, N_CONT);
        for (int i = 0; i < 40; i++) begin
            repeat ($random(seed) & 31) @(posedge clk);
            read_status(word);
        end

        pix_mode = PIX_NONE;
        write_reg(REG_CTRL, 16'h0000);
        wait_frames(1);
        pix_mode = PIX_BLACK;
        wait_frames(2);

        $display("run complete, %0d error(s) over %0d frames", errors, frames);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
verilog/vdp_pkg.sv
verilog/vdp_vram.sv
verilog/vdp_palette.sv
verilog/vdp_raster_timer.sv
verilog/vdp_pixel_fetch.sv
verilog/vdp_bus_ctrl.sv
verilog/vdp_top.sv
verification/tb_vdp.sv
